//--- common/tile_io_pkg.sv
`default_nettype none

package tile_io_pkg;

  // payload and id widths
  typedef logic [23:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [0:0]  src_id_t;
  typedef logic [3:0]  dev_id_t;
  typedef logic [15:0] ofs_t;

  // routed devices, also the link index at the top level
  typedef enum logic [1:0]
  {
    dev_cfg      = 2'd0,
    dev_clint    = 2'd1,
    dev_loopback = 2'd2
  } dev_sel_t;

  localparam int NUM_SRC = 2;
  localparam int NUM_DEV = 3;

  // requester numbers
  localparam src_id_t SRC_FE = 1'b0;
  localparam src_id_t SRC_BE = 1'b1;

  // device field sits in address bits 23:20
  localparam int      DEV_ID_LSB   = 20;
  localparam dev_id_t CFG_DEV_ID   = 4'd2;
  localparam dev_id_t CLINT_DEV_ID = 4'd3;

  // cfg register offsets
  localparam ofs_t CFG_FREEZE_OFS  = 16'h0004;
  localparam ofs_t CFG_NPC_OFS     = 16'h0008;
  localparam ofs_t CFG_CORE_ID_OFS = 16'h000c;

  // clint register offsets
  localparam ofs_t CLINT_MSIP_OFS     = 16'h0000;
  localparam ofs_t CLINT_MTIMECMP_OFS = 16'h4000;
  localparam ofs_t CLINT_MTIME_OFS    = 16'hbff8;

  // reset values and constants
  localparam word_t FREEZE_RESET   = 32'h0000_0001;
  localparam word_t NPC_RESET      = 32'h0011_0000;
  localparam word_t CORE_ID        = 32'h0000_0005;
  localparam word_t MTIMECMP_RESET = 32'hffff_ffff;

endpackage

`default_nettype wire

//--- common/mem_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_link_if;

  // forward channel, router to device
  logic                 fwd_v;
  tile_io_pkg::addr_t   fwd_addr;
  logic                 fwd_we;
  tile_io_pkg::word_t   fwd_wdata;
  tile_io_pkg::src_id_t fwd_src;
  logic                 fwd_ready;

  // reverse channel, device to router
  logic                 rev_v;
  tile_io_pkg::word_t   rev_rdata;
  tile_io_pkg::src_id_t rev_src;
  logic                 rev_ready;

  modport router_fwd (output fwd_v, fwd_addr, fwd_we, fwd_wdata, fwd_src, input fwd_ready);

  modport router_rev (input rev_v, rev_rdata, rev_src, output rev_ready);

  modport device (input fwd_v, fwd_addr, fwd_we, fwd_wdata, fwd_src, rev_ready,
                  output fwd_ready, rev_v, rev_rdata, rev_src);

endinterface

`default_nettype wire

//--- devices/cfg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_slice
  (
    input  logic       clk_i,
    input  logic       reset_i,
    mem_link_if.device link,
    output logic       freeze_o
  );

  logic                 freeze_q;
  tile_io_pkg::word_t   npc_q;

  logic                 rsp_v_q;
  tile_io_pkg::word_t   rsp_rdata_q;
  tile_io_pkg::src_id_t rsp_src_q;

  tile_io_pkg::ofs_t    ofs;
  tile_io_pkg::word_t   rd_data;
  logic                 accept;

  // one response in flight at most
  assign link.fwd_ready = ~rsp_v_q;
  assign accept         = link.fwd_v & ~rsp_v_q;
  assign ofs            = tile_io_pkg::ofs_t'(link.fwd_addr);

  always_comb
  begin
    case (ofs)
      tile_io_pkg::CFG_FREEZE_OFS:  rd_data = tile_io_pkg::word_t'(freeze_q);
      tile_io_pkg::CFG_NPC_OFS:     rd_data = npc_q;
      tile_io_pkg::CFG_CORE_ID_OFS: rd_data = tile_io_pkg::CORE_ID;
      default:                      rd_data = '0;
    endcase
  end

  // core id is read only
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_q <= tile_io_pkg::FREEZE_RESET[0];
      npc_q    <= tile_io_pkg::NPC_RESET;
    end
    else if (accept && link.fwd_we)
    begin
      case (ofs)
        tile_io_pkg::CFG_FREEZE_OFS: freeze_q <= link.fwd_wdata[0];
        tile_io_pkg::CFG_NPC_OFS:    npc_q    <= link.fwd_wdata;
        default:                     ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      rsp_v_q <= 1'b1;
    end
    else if (link.rev_ready)
    begin
      rsp_v_q <= 1'b0;
    end
  end

  // writes answer with zero
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_rdata_q <= link.fwd_we ? '0 : rd_data;
      rsp_src_q   <= link.fwd_src;
    end
  end

  assign link.rev_v     = rsp_v_q;
  assign link.rev_rdata = rsp_rdata_q;
  assign link.rev_src   = rsp_src_q;
  assign freeze_o       = freeze_q;

endmodule

`default_nettype wire

//--- devices/clint_slice.sv
`timescale 1ns/1ps
`default_nettype none

module clint_slice
  (
    input  logic       clk_i,
    input  logic       reset_i,
    mem_link_if.device link,
    output logic       software_irq_o,
    output logic       timer_irq_o
  );

  logic                 msip_q;
  tile_io_pkg::word_t   mtime_q;
  tile_io_pkg::word_t   mtimecmp_q;
  logic                 timer_irq_q;

  logic                 rsp_v_q;
  tile_io_pkg::word_t   rsp_rdata_q;
  tile_io_pkg::src_id_t rsp_src_q;

  tile_io_pkg::ofs_t    ofs;
  tile_io_pkg::word_t   rd_data;
  logic                 accept;
  logic                 wr_en;

  assign link.fwd_ready = ~rsp_v_q;
  assign accept         = link.fwd_v & ~rsp_v_q;
  assign wr_en          = accept & link.fwd_we;
  assign ofs            = tile_io_pkg::ofs_t'(link.fwd_addr);

  always_comb
  begin
    case (ofs)
      tile_io_pkg::CLINT_MSIP_OFS:     rd_data = tile_io_pkg::word_t'(msip_q);
      tile_io_pkg::CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
      tile_io_pkg::CLINT_MTIME_OFS:    rd_data = mtime_q;
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      msip_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= tile_io_pkg::MTIMECMP_RESET;
      timer_irq_q <= 1'b0;
    end
    else
    begin
      // compare sees the previous cycle's values
      timer_irq_q <= (mtime_q >= mtimecmp_q);

      // timer runs on clk_i, a write overrides the increment
      if (wr_en && (ofs == tile_io_pkg::CLINT_MTIME_OFS))
      begin
        mtime_q <= link.fwd_wdata;
      end
      else
      begin
        mtime_q <= mtime_q + 1'b1;
      end

      if (wr_en && (ofs == tile_io_pkg::CLINT_MSIP_OFS))
      begin
        msip_q <= link.fwd_wdata[0];
      end

      if (wr_en && (ofs == tile_io_pkg::CLINT_MTIMECMP_OFS))
      begin
        mtimecmp_q <= link.fwd_wdata;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      rsp_v_q <= 1'b1;
    end
    else if (link.rev_ready)
    begin
      rsp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_rdata_q <= link.fwd_we ? '0 : rd_data;
      rsp_src_q   <= link.fwd_src;
    end
  end

  assign link.rev_v     = rsp_v_q;
  assign link.rev_rdata = rsp_rdata_q;
  assign link.rev_src   = rsp_src_q;

  assign software_irq_o = msip_q;
  assign timer_irq_o    = timer_irq_q;

endmodule

`default_nettype wire

//--- devices/loopback_slice.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_slice
  (
    input  logic       clk_i,
    input  logic       reset_i,
    mem_link_if.device link
  );

  logic                 rsp_v_q;
  tile_io_pkg::src_id_t rsp_src_q;
  logic                 accept;

  // catches every unclaimed address, writes are dropped
  assign link.fwd_ready = ~rsp_v_q;
  assign accept         = link.fwd_v & ~rsp_v_q;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      rsp_v_q <= 1'b1;
    end
    else if (link.rev_ready)
    begin
      rsp_v_q <= 1'b0;
    end
  end

  // only the return id needs holding
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_src_q <= link.fwd_src;
    end
  end

  assign link.rev_v     = rsp_v_q;
  assign link.rev_rdata = '0;
  assign link.rev_src   = rsp_src_q;

endmodule

`default_nettype wire

//--- hdl/fwd_route.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_route
  (
    input  logic                                          clk_i,
    input  logic                                          reset_i,

    input  logic               [tile_io_pkg::NUM_SRC-1:0] fwd_v_i,
    input  tile_io_pkg::addr_t [tile_io_pkg::NUM_SRC-1:0] fwd_addr_i,
    input  logic               [tile_io_pkg::NUM_SRC-1:0] fwd_we_i,
    input  tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0] fwd_wdata_i,
    output logic               [tile_io_pkg::NUM_SRC-1:0] fwd_ready_o,

    mem_link_if.router_fwd dev_link [tile_io_pkg::NUM_DEV]
  );

  tile_io_pkg::dev_sel_t dev_sel [tile_io_pkg::NUM_SRC];

  logic                 [tile_io_pkg::NUM_DEV-1:0] gnt_v;
  tile_io_pkg::src_id_t [tile_io_pkg::NUM_DEV-1:0] gnt_src;
  logic                 [tile_io_pkg::NUM_DEV-1:0] dev_ready;

  // round-robin pointer per device
  tile_io_pkg::src_id_t [tile_io_pkg::NUM_DEV-1:0] rr_q;

  // destination decode from the device field
  always_comb
  begin
    for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
    begin
      case (fwd_addr_i[s][tile_io_pkg::DEV_ID_LSB +: $bits(tile_io_pkg::dev_id_t)])
        tile_io_pkg::CFG_DEV_ID:   dev_sel[s] = tile_io_pkg::dev_cfg;
        tile_io_pkg::CLINT_DEV_ID: dev_sel[s] = tile_io_pkg::dev_clint;
        default:                   dev_sel[s] = tile_io_pkg::dev_loopback;
      endcase
    end
  end

  // scan down from the farthest candidate so the one nearest the pointer wins
  always_comb
  begin
    tile_io_pkg::src_id_t cand;
    cand = '0;
    for (int d = 0; d < tile_io_pkg::NUM_DEV; d++)
    begin
      gnt_v[d]   = 1'b0;
      gnt_src[d] = rr_q[d];
      for (int k = tile_io_pkg::NUM_SRC - 1; k >= 0; k--)
      begin
        cand = tile_io_pkg::src_id_t'(rr_q[d] + k);
        if (fwd_v_i[cand] && (dev_sel[cand] == tile_io_pkg::dev_sel_t'(d)))
        begin
          gnt_v[d]   = 1'b1;
          gnt_src[d] = cand;
        end
      end
    end
  end

  // a requester only targets one device at a time
  always_comb
  begin
    fwd_ready_o = '0;
    for (int d = 0; d < tile_io_pkg::NUM_DEV; d++)
    begin
      if (gnt_v[d] && dev_ready[d])
      begin
        fwd_ready_o[gnt_src[d]] = 1'b1;
      end
    end
  end

  // pointer moves one past the winner on each transfer
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rr_q <= '0;
    end
    else
    begin
      for (int d = 0; d < tile_io_pkg::NUM_DEV; d++)
      begin
        if (gnt_v[d] && dev_ready[d])
        begin
          rr_q[d] <= tile_io_pkg::src_id_t'(gnt_src[d] + 1'b1);
        end
      end
    end
  end

  for (genvar d = 0; d < tile_io_pkg::NUM_DEV; d++)
  begin : g_link
    assign dev_link[d].fwd_v     = gnt_v[d];
    assign dev_link[d].fwd_addr  = fwd_addr_i[gnt_src[d]];
    assign dev_link[d].fwd_we    = fwd_we_i[gnt_src[d]];
    assign dev_link[d].fwd_wdata = fwd_wdata_i[gnt_src[d]];
    assign dev_link[d].fwd_src   = gnt_src[d];
    assign dev_ready[d]          = dev_link[d].fwd_ready;
  end

endmodule

`default_nettype wire

//--- hdl/rev_route.sv
`timescale 1ns/1ps
`default_nettype none

module rev_route
  (
    input  logic                                          clk_i,
    input  logic                                          reset_i,

    mem_link_if.router_rev dev_link [tile_io_pkg::NUM_DEV],

    output logic               [tile_io_pkg::NUM_SRC-1:0] rev_v_o,
    output tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0] rev_rdata_o,
    input  logic               [tile_io_pkg::NUM_SRC-1:0] rev_ready_i
  );

  logic                 [tile_io_pkg::NUM_DEV-1:0] dev_v;
  tile_io_pkg::word_t   [tile_io_pkg::NUM_DEV-1:0] dev_rdata;
  tile_io_pkg::src_id_t [tile_io_pkg::NUM_DEV-1:0] dev_src;
  logic                 [tile_io_pkg::NUM_DEV-1:0] dev_ready;

  // lowest device number holding a response for this requester wins
  always_comb
  begin
    logic found;
    found       = 1'b0;
    rev_v_o     = '0;
    rev_rdata_o = '0;
    dev_ready   = '0;
    for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
    begin
      found = 1'b0;
      for (int d = 0; d < tile_io_pkg::NUM_DEV; d++)
      begin
        if (!found && dev_v[d] && (dev_src[d] == tile_io_pkg::src_id_t'(s)))
        begin
          found          = 1'b1;
          rev_v_o[s]     = 1'b1;
          rev_rdata_o[s] = dev_rdata[d];
          // ready goes back to the picked device only
          dev_ready[d]   = rev_ready_i[s];
        end
      end
    end
  end

  for (genvar d = 0; d < tile_io_pkg::NUM_DEV; d++)
  begin : g_link
    assign dev_v[d]               = dev_link[d].rev_v;
    assign dev_rdata[d]           = dev_link[d].rev_rdata;
    assign dev_src[d]             = dev_link[d].rev_src;
    assign dev_link[d].rev_ready  = dev_ready[d];
  end

endmodule

`default_nettype wire

//--- hdl/tile_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tile_io_top
  (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,

    // requests, one lane per requester
    input  logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_v_i,
    input  tile_io_pkg::addr_t [tile_io_pkg::NUM_SRC-1:0]        fwd_addr_i,
    input  logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_we_i,
    input  tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0]        fwd_wdata_i,
    output logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_ready_o,

    // responses
    output logic               [tile_io_pkg::NUM_SRC-1:0]        rev_v_o,
    output tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0]        rev_rdata_o,
    input  logic               [tile_io_pkg::NUM_SRC-1:0]        rev_ready_i,

    output logic                                                 freeze_o,
    output logic                                                 software_irq_o,
    output logic                                                 timer_irq_o
  );

  // one link per device, indexed by dev_sel_t
  mem_link_if dev_link [tile_io_pkg::NUM_DEV] ();

  fwd_route i_fwd_route
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fwd_v_i     (fwd_v_i),
      .fwd_addr_i  (fwd_addr_i),
      .fwd_we_i    (fwd_we_i),
      .fwd_wdata_i (fwd_wdata_i),
      .fwd_ready_o (fwd_ready_o),
      .dev_link    (dev_link)
    );

  rev_route i_rev_route
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .dev_link    (dev_link),
      .rev_v_o     (rev_v_o),
      .rev_rdata_o (rev_rdata_o),
      .rev_ready_i (rev_ready_i)
    );

  cfg_slice i_cfg_slice
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .link     (dev_link[tile_io_pkg::dev_cfg]),
      .freeze_o (freeze_o)
    );

  clint_slice i_clint_slice
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .link           (dev_link[tile_io_pkg::dev_clint]),
      .software_irq_o (software_irq_o),
      .timer_irq_o    (timer_irq_o)
    );

  loopback_slice i_loopback_slice
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .link    (dev_link[tile_io_pkg::dev_loopback])
    );

endmodule

`default_nettype wire

//--- testbench/tb_tile_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_io;

  typedef enum {chk_none, chk_data, chk_mono} chk_e;
  typedef enum {out_none, out_freeze, out_sw_irq, out_timer_irq} out_e;
  typedef enum {lane_idle, lane_req, lane_rsp, lane_out, lane_done} lane_e;

  // one request with its expected outcome
  typedef struct {
    int                 src;
    logic               we;
    tile_io_pkg::addr_t addr;
    tile_io_pkg::word_t wdata;
    tile_io_pkg::word_t exp;
    chk_e               chk;
    out_e               out_sel;
    logic               out_exp;
  } entry_t;

  logic                                                 clk_i;
  logic                                                 reset_i;
  logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_v_i;
  tile_io_pkg::addr_t [tile_io_pkg::NUM_SRC-1:0]        fwd_addr_i;
  logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_we_i;
  tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0]        fwd_wdata_i;
  logic               [tile_io_pkg::NUM_SRC-1:0]        fwd_ready_o;
  logic               [tile_io_pkg::NUM_SRC-1:0]        rev_v_o;
  tile_io_pkg::word_t [tile_io_pkg::NUM_SRC-1:0]        rev_rdata_o;
  logic               [tile_io_pkg::NUM_SRC-1:0]        rev_ready_i;
  logic                                                 freeze_o;
  logic                                                 software_irq_o;
  logic                                                 timer_irq_o;

  entry_t table_q [$];
  int     errors;
  int     checks;

  // first table index of the section both requesters run together
  int     shared_start;
  logic   shared_go;

  // per requester progress through the table
  lane_e              state      [tile_io_pkg::NUM_SRC];
  int                 cur        [tile_io_pkg::NUM_SRC];
  int                 wait_cnt   [tile_io_pkg::NUM_SRC];
  tile_io_pkg::word_t last_mtime [tile_io_pkg::NUM_SRC];
  logic               have_mtime [tile_io_pkg::NUM_SRC];
  logic               at_barrier [tile_io_pkg::NUM_SRC];
  logic               req_fire   [tile_io_pkg::NUM_SRC];
  logic               rsp_fire   [tile_io_pkg::NUM_SRC];
  tile_io_pkg::word_t rsp_data   [tile_io_pkg::NUM_SRC];

  tile_io_top i_tile_io_top
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .fwd_v_i        (fwd_v_i),
      .fwd_addr_i     (fwd_addr_i),
      .fwd_we_i       (fwd_we_i),
      .fwd_wdata_i    (fwd_wdata_i),
      .fwd_ready_o    (fwd_ready_o),
      .rev_v_o        (rev_v_o),
      .rev_rdata_o    (rev_rdata_o),
      .rev_ready_i    (rev_ready_i),
      .freeze_o       (freeze_o),
      .software_irq_o (software_irq_o),
      .timer_irq_o    (timer_irq_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // device field in bits 23:20, register offset in the low 16 bits
  function automatic tile_io_pkg::addr_t dev_addr(input tile_io_pkg::dev_id_t dev,
                                                  input tile_io_pkg::ofs_t ofs);
    return {dev, 4'h0, ofs};
  endfunction

  task automatic check_value(input string name, input tile_io_pkg::word_t got,
                             input tile_io_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic add_entry(input int src, input logic we, input tile_io_pkg::addr_t addr,
                           input tile_io_pkg::word_t wdata, input tile_io_pkg::word_t exp,
                           input chk_e chk, input out_e out_sel, input logic out_exp);
    entry_t e;
    e.src     = src;
    e.we      = we;
    e.addr    = addr;
    e.wdata   = wdata;
    e.exp     = exp;
    e.chk     = chk;
    e.out_sel = out_sel;
    e.out_exp = out_exp;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    tile_io_pkg::addr_t frz;
    tile_io_pkg::addr_t npc;
    tile_io_pkg::addr_t cid;
    tile_io_pkg::addr_t msip;
    tile_io_pkg::addr_t cmp;
    tile_io_pkg::addr_t mtime;
    tile_io_pkg::addr_t lb0;
    tile_io_pkg::addr_t lbf;
    frz   = dev_addr(tile_io_pkg::CFG_DEV_ID, tile_io_pkg::CFG_FREEZE_OFS);
    npc   = dev_addr(tile_io_pkg::CFG_DEV_ID, tile_io_pkg::CFG_NPC_OFS);
    cid   = dev_addr(tile_io_pkg::CFG_DEV_ID, tile_io_pkg::CFG_CORE_ID_OFS);
    msip  = dev_addr(tile_io_pkg::CLINT_DEV_ID, tile_io_pkg::CLINT_MSIP_OFS);
    cmp   = dev_addr(tile_io_pkg::CLINT_DEV_ID, tile_io_pkg::CLINT_MTIMECMP_OFS);
    mtime = dev_addr(tile_io_pkg::CLINT_DEV_ID, tile_io_pkg::CLINT_MTIME_OFS);
    lb0   = dev_addr(4'h0, 16'h0040);
    lbf   = dev_addr(4'hf, 16'h1234);

    // fe walks the cfg slice
    add_entry(0, 1'b0, frz, 32'h0, tile_io_pkg::FREEZE_RESET, chk_data, out_none, 1'b0);
    add_entry(0, 1'b0, npc, 32'h0, tile_io_pkg::NPC_RESET, chk_data, out_none, 1'b0);
    add_entry(0, 1'b0, cid, 32'h0, tile_io_pkg::CORE_ID, chk_data, out_none, 1'b0);
    add_entry(0, 1'b1, frz, 32'h0, 32'h0, chk_none, out_freeze, 1'b0);
    add_entry(0, 1'b0, frz, 32'h0, 32'h0, chk_data, out_none, 1'b0);
    add_entry(0, 1'b1, npc, 32'h8000_1234, 32'h0, chk_none, out_none, 1'b0);
    add_entry(0, 1'b0, npc, 32'h0, 32'h8000_1234, chk_data, out_none, 1'b0);
    add_entry(0, 1'b1, cid, 32'hdead_beef, 32'h0, chk_none, out_none, 1'b0);
    add_entry(0, 1'b0, cid, 32'h0, tile_io_pkg::CORE_ID, chk_data, out_none, 1'b0);
    add_entry(0, 1'b0, frz + 24'h0c, 32'h0, 32'h0, chk_data, out_none, 1'b0);
    add_entry(0, 1'b1, frz, 32'h1, 32'h0, chk_none, out_freeze, 1'b1);

    // be walks the clint slice
    add_entry(1, 1'b0, msip, 32'h0, 32'h0, chk_data, out_none, 1'b0);
    add_entry(1, 1'b1, msip, 32'h1, 32'h0, chk_none, out_sw_irq, 1'b1);
    add_entry(1, 1'b0, msip, 32'h0, 32'h1, chk_data, out_none, 1'b0);
    add_entry(1, 1'b1, msip, 32'h0, 32'h0, chk_none, out_sw_irq, 1'b0);
    add_entry(1, 1'b0, cmp, 32'h0, tile_io_pkg::MTIMECMP_RESET, chk_data, out_none, 1'b0);
    add_entry(1, 1'b0, mtime, 32'h0, 32'h0, chk_mono, out_none, 1'b0);
    add_entry(1, 1'b1, cmp, 32'h20, 32'h0, chk_none, out_timer_irq, 1'b1);
    add_entry(1, 1'b0, cmp, 32'h0, 32'h20, chk_data, out_none, 1'b0);
    add_entry(1, 1'b0, mtime, 32'h0, 32'h0, chk_mono, out_none, 1'b0);
    add_entry(1, 1'b1, cmp, 32'hffff_ffff, 32'h0, chk_none, out_timer_irq, 1'b0);
    add_entry(1, 1'b0, msip + 24'h100, 32'h0, 32'h0, chk_data, out_none, 1'b0);

    // both requesters share the loopback and cfg devices
    shared_start = table_q.size();
    for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
    begin
      add_entry(s, 1'b0, lb0, 32'h0, 32'h0, chk_data, out_none, 1'b0);
      add_entry(s, 1'b0, cid, 32'h0, tile_io_pkg::CORE_ID, chk_data, out_none, 1'b0);
      add_entry(s, 1'b1, lbf, 32'h5a5a_0000, 32'h0, chk_none, out_none, 1'b0);
      add_entry(s, 1'b0, lbf, 32'h0, 32'h0, chk_data, out_none, 1'b0);
      add_entry(s, 1'b0, cid, 32'h0, tile_io_pkg::CORE_ID, chk_data, out_none, 1'b0);
      add_entry(s, 1'b0, lb0, 32'h0, 32'h0, chk_data, out_none, 1'b0);
    end
  endtask

  function automatic int next_entry(input int s, input int start);
    for (int i = start; i < table_q.size(); i++)
    begin
      if (table_q[i].src == s)
      begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic output_value(input out_e sel);
    case (sel)
      out_freeze:    return freeze_o;
      out_sw_irq:    return software_irq_o;
      out_timer_irq: return timer_irq_o;
      default:       return 1'b0;
    endcase
  endfunction

  function automatic string output_name(input out_e sel);
    case (sel)
      out_freeze:    return "freeze_o";
      out_sw_irq:    return "software_irq_o";
      out_timer_irq: return "timer_irq_o";
      default:       return "none";
    endcase
  endfunction

  task automatic check_response(input int s);
    entry_t e;
    e = table_q[cur[s]];
    case (e.chk)
      chk_data: check_value($sformatf("rev_rdata_o[%0d] at %h", s, e.addr), rsp_data[s], e.exp);
      chk_mono:
      begin
        // mtime must not go backwards between reads
        if (have_mtime[s])
        begin
          check_value($sformatf("mtime >= previous on port %0d", s),
                      tile_io_pkg::word_t'(rsp_data[s] >= last_mtime[s]), 32'h1);
        end
        last_mtime[s] = rsp_data[s];
        have_mtime[s] = 1'b1;
      end
      default: ;
    endcase
  endtask

  // runs at each falling edge, after the transfers of the last rising edge
  task automatic advance_lane(input int s);
    entry_t e;
    logic   got;
    int     nxt;
    if (rsp_fire[s])
    begin
      if (state[s] != lane_rsp)
      begin
        $display("error: requester %0d got a response with no request outstanding", s);
        errors++;
      end
      else
      begin
        check_response(s);
        wait_cnt[s] = 0;
        state[s]    = (table_q[cur[s]].out_sel == out_none) ? lane_idle : lane_out;
      end
    end
    if (req_fire[s])
    begin
      fwd_v_i[s] = 1'b0;
      state[s]   = lane_rsp;
    end
    if (state[s] == lane_out)
    begin
      e   = table_q[cur[s]];
      got = output_value(e.out_sel);
      // the timer compare may need a few cycles to trip
      if ((got === e.out_exp) || (wait_cnt[s] >= 64))
      begin
        check_value(output_name(e.out_sel), tile_io_pkg::word_t'(got),
                    tile_io_pkg::word_t'(e.out_exp));
        state[s] = lane_idle;
      end
      else
      begin
        wait_cnt[s]++;
      end
    end
    if (state[s] == lane_idle)
    begin
      nxt = next_entry(s, cur[s] + 1);
      if (nxt < 0)
      begin
        state[s] = lane_done;
      end
      else if ((nxt >= shared_start) && !shared_go)
      begin
        // wait here so both requesters enter the shared section together
        at_barrier[s] = 1'b1;
      end
      else
      begin
        cur[s]         = nxt;
        e              = table_q[nxt];
        fwd_addr_i[s]  = e.addr;
        fwd_we_i[s]    = e.we;
        fwd_wdata_i[s] = e.wdata;
        fwd_v_i[s]     = 1'b1;
        state[s]       = lane_req;
      end
    end
    rev_ready_i[s] = ($urandom % 4) != 0;
  endtask

  initial
  begin
    int limit;
    int cycles;
    void'($urandom(32'h84d5));
    errors      = 0;
    checks      = 0;
    shared_go   = 1'b0;
    reset_i     = 1'b1;
    fwd_v_i     = '0;
    fwd_addr_i  = '0;
    fwd_we_i    = '0;
    fwd_wdata_i = '0;
    rev_ready_i = '0;
    for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
    begin
      state[s]      = lane_idle;
      cur[s]        = -1;
      wait_cnt[s]   = 0;
      last_mtime[s] = '0;
      have_mtime[s] = 1'b0;
      at_barrier[s] = 1'b0;
      req_fire[s]   = 1'b0;
      rsp_fire[s]   = 1'b0;
      rsp_data[s]   = '0;
    end
    build_table();
    limit  = table_q.size() * 20;
    cycles = 0;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_value("rev_v_o", tile_io_pkg::word_t'(rev_v_o), 32'h0);
    check_value("software_irq_o", tile_io_pkg::word_t'(software_irq_o), 32'h0);
    check_value("timer_irq_o", tile_io_pkg::word_t'(timer_irq_o), 32'h0);
    check_value("freeze_o", tile_io_pkg::word_t'(freeze_o), 32'h1);

    while (!((state[0] == lane_done) && (state[1] == lane_done)) && (cycles < limit))
    begin
      @(negedge clk_i);
      cycles++;
      shared_go = at_barrier[0] && at_barrier[1];
      for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
      begin
        advance_lane(s);
      end
      // handshakes seen here complete at the next rising edge
      #1;
      for (int s = 0; s < tile_io_pkg::NUM_SRC; s++)
      begin
        req_fire[s] = fwd_v_i[s] & fwd_ready_o[s];
        rsp_fire[s] = rev_v_o[s] & rev_ready_i[s];
        rsp_data[s] = rev_rdata_o[s];
      end
    end

    if (!((state[0] == lane_done) && (state[1] == lane_done)))
    begin
      $display("error: timeout after %0d cycles with requests still outstanding", cycles);
      errors++;
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tile_io.f
common/tile_io_pkg.sv
common/mem_link_if.sv
devices/cfg_slice.sv
devices/clint_slice.sv
devices/loopback_slice.sv
hdl/fwd_route.sv
hdl/rev_route.sv
hdl/tile_io_top.sv
testbench/tb_tile_io.sv

//--- Makefile
TOP := tb_tile_io

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tile_io.f

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
